/* hdl/cpu_isa_pkg.sv */
//****************************************
// test processor instruction set
// opcodes, register selects, microword union, data pattern
//****************************************

package cpu_isa_pkg;

   localparam int PC_WIDTH = 8;

   typedef enum logic [3:0] {
      OP_NOP   = 4'd0,
      OP_WRITE = 4'd1,
      OP_READ  = 4'd2,
      OP_ADD   = 4'd3,
      OP_SUB   = 4'd4,
      OP_TST   = 4'd5,
      OP_CMP   = 4'd6,
      OP_JMP   = 4'd7,
      OP_DONE  = 4'd8,
      OP_FAULT = 4'd15
   } opcode_t;

   typedef enum logic [2:0] {
      R_NONE = 3'd0,
      R_A    = 3'd1,
      R_B    = 3'd2,
      R_C    = 3'd3,
      R_D    = 3'd4,
      R_I    = 3'd5,            // immediate
      R_DD   = 3'd7             // pattern for current address
   } reg_sel_t;

   typedef struct packed {
      opcode_t     op;
      reg_sel_t    dreg;
      reg_sel_t    sreg;
      logic [5:0]  spare;
      logic [31:0] imm;
   } alu_word_t;

   typedef struct packed {
      opcode_t     op;
      reg_sel_t    dreg;
      reg_sel_t    sreg;
      logic [7:0]  target;
      logic [29:0] cmp_val;     // zero extended on use
   } branch_word_t;

   typedef union packed {
      alu_word_t    alu;
      branch_word_t br;
   } microword_u;

   // inverted address in the upper half, address in the lower half
   function automatic logic [31:0] pattern_of(input logic [15:0] addr_lo);
      return {~addr_lo, addr_lo};
   endfunction

endpackage

/* hdl/bus_pkg.sv */
//****************************************
// memory bus widths and test block base
//****************************************

package bus_pkg;

   localparam int ADDR_WIDTH = 22;
   localparam int DATA_WIDTH = 32;

   localparam logic [ADDR_WIDTH-1:0] MEM_BASE = 22'h000100;

endpackage

/* hdl/microcode_rom.sv */
//****************************************
// registered microcode rom
// fill, verify and finish program
//****************************************
`timescale 1ns/100ps

module microcode_rom import cpu_isa_pkg::*;
#(
   parameter int BLOCK_WORDS = 16
)
(
   input  logic                clk,
   input  logic                reset,
   input  logic [PC_WIDTH-1:0] addr,
   output microword_u          word
);

   localparam logic [29:0] BOUND = 30'(BLOCK_WORDS);

   function automatic microword_u alu_w(input opcode_t op, input reg_sel_t dreg,
                                        input reg_sel_t sreg, input logic [31:0] imm);
      microword_u w;
      w.alu.op    = op;
      w.alu.dreg  = dreg;
      w.alu.sreg  = sreg;
      w.alu.spare = '0;
      w.alu.imm   = imm;
      return w;
   endfunction

   function automatic microword_u br_w(input opcode_t op, input reg_sel_t dreg,
                                       input reg_sel_t sreg, input logic [7:0] target,
                                       input logic [29:0] cmp_val);
      microword_u w;
      w.br.op      = op;
      w.br.dreg    = dreg;
      w.br.sreg    = sreg;
      w.br.target  = target;
      w.br.cmp_val = cmp_val;
      return w;
   endfunction

   always_ff @(posedge clk)
   begin
      if (reset)
         word <= '0;
      else
      begin
         case (addr)
            8'h00: word <= alu_w(OP_ADD, R_A, R_NONE, 32'd0);          // a = 0
            8'h01: word <= alu_w(OP_ADD, R_B, R_NONE, 32'd0);          // b = 0 (count)
            8'h02: word <= alu_w(OP_ADD, R_D, R_DD, 32'd0);            // d = pattern
            8'h03: word <= alu_w(OP_WRITE, R_NONE, R_NONE, 32'd0);     // m[a] = d
            8'h04: word <= alu_w(OP_ADD, R_A, R_A, 32'd1);             // a++
            8'h05: word <= alu_w(OP_ADD, R_B, R_B, 32'd1);             // b++
            8'h06: word <= br_w(OP_CMP, R_B, R_I, 8'h08, BOUND);       // fill done
            8'h07: word <= br_w(OP_JMP, R_NONE, R_NONE, 8'h02, 30'd0);
            8'h08: word <= alu_w(OP_ADD, R_A, R_NONE, 32'd0);
            8'h09: word <= alu_w(OP_ADD, R_B, R_NONE, 32'd0);
            8'h0a: word <= alu_w(OP_READ, R_NONE, R_NONE, 32'd0);      // d = m[a]
            8'h0b: word <= br_w(OP_CMP, R_D, R_DD, 8'h0d, 30'd0);      // match skips fault
            8'h0c: word <= alu_w(OP_FAULT, R_NONE, R_NONE, 32'd0);
            8'h0d: word <= alu_w(OP_ADD, R_A, R_A, 32'd1);
            8'h0e: word <= alu_w(OP_ADD, R_B, R_B, 32'd1);
            8'h0f: word <= br_w(OP_CMP, R_B, R_I, 8'h11, BOUND);
            8'h10: word <= br_w(OP_JMP, R_NONE, R_NONE, 8'h0a, 30'd0);
            8'h11: word <= alu_w(OP_DONE, R_NONE, R_NONE, 32'd0);
            default: word <= br_w(OP_JMP, R_NONE, R_NONE, 8'h00, 30'd0);
         endcase
      end
   end

endmodule

/* hdl/test_cpu.sv */
//****************************************
// microcoded test processor
// pc, stall and branch logic, registers, alu
//****************************************
`timescale 1ns/100ps

module test_cpu import cpu_isa_pkg::*, bus_pkg::*;
#(
   parameter int BLOCK_WORDS = 16
)
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  run,
   input  logic                  clear,
   output logic                  finish,
   output logic                  is_fault,
   output logic                  op_start,
   output logic                  op_write,
   output logic [ADDR_WIDTH-1:0] op_addr,
   output logic [DATA_WIDTH-1:0] op_wdata,
   input  logic                  op_done,
   input  logic [DATA_WIDTH-1:0] op_rdata
);

   microword_u            ir;
   opcode_t               op;
   reg_sel_t              dreg;
   reg_sel_t              sreg;
   logic [PC_WIDTH-1:0]   pc;
   logic [PC_WIDTH-1:0]   npc;
   logic [PC_WIDTH-1:0]   rom_addr;
   logic [DATA_WIDTH-1:0] a, b, c, d;
   logic [DATA_WIDTH-1:0] imm_val, src, dst, dd, alu_res;
   logic                  is_branch, mem_op, halt_op, stall, load_pc;
   logic                  issued;    // bus op handed to bus_master
   logic                  finished;

   assign op   = ir.alu.op;
   assign dreg = ir.alu.dreg;
   assign sreg = ir.alu.sreg;

   assign is_branch = (op == OP_TST) || (op == OP_CMP) || (op == OP_JMP);
   assign mem_op    = (op == OP_WRITE) || (op == OP_READ);
   assign halt_op   = (op == OP_DONE) || (op == OP_FAULT);
   assign imm_val   = is_branch ? {2'b00, ir.br.cmp_val} : ir.alu.imm;

   assign op_addr  = MEM_BASE + a[ADDR_WIDTH-1:0];
   assign op_wdata = d;
   assign op_write = (op == OP_WRITE);
   assign dd       = pattern_of(op_addr[15:0]);

   always_comb
   begin
      case (sreg)
         R_A:     src = a;
         R_B:     src = b;
         R_C:     src = c;
         R_D:     src = d;
         R_I:     src = imm_val;
         R_DD:    src = dd;
         default: src = '0;
      endcase
      case (dreg)
         R_A:     dst = a;
         R_B:     dst = b;
         R_C:     dst = c;
         R_D:     dst = d;
         default: dst = '0;
      endcase
   end

   assign alu_res = (op == OP_SUB) ? src - ir.alu.imm : src + ir.alu.imm;

   assign stall   = !run || halt_op || (mem_op && !op_done);
   assign load_pc = ((op == OP_TST) && ~|(dst & src)) ||
                    ((op == OP_CMP) && (dst == src)) ||
                    (op == OP_JMP);
   assign npc      = load_pc ? ir.br.target : pc + 1'b1;
   assign rom_addr = clear ? '0 : (stall ? pc : npc);

   microcode_rom #(
      .BLOCK_WORDS(BLOCK_WORDS)
   ) rom (
      .clk  (clk),
      .reset(reset),
      .addr (rom_addr),
      .word (ir)
   );

   always_ff @(posedge clk)
   begin
      if (reset || clear)
         pc <= '0;
      else if (!stall)
         pc <= npc;
   end

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         a <= '0;
         b <= '0;
         c <= '0;
         d <= '0;
      end
      else if (op_done && op == OP_READ)
         d <= op_rdata;
      else if (!stall && (op == OP_ADD || op == OP_SUB))
      begin
         case (dreg)
            R_A:     a <= alu_res;
            R_B:     b <= alu_res;
            R_C:     c <= alu_res;
            R_D:     d <= alu_res;
            default: ;
         endcase
      end
   end

   // one start pulse per fetched memory op
   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         op_start <= 1'b0;
         issued   <= 1'b0;
      end
      else
      begin
         op_start <= run && mem_op && !issued;
         if (op_done)
            issued <= 1'b0;
         else if (run && mem_op)
            issued <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         finish   <= 1'b0;
         finished <= 1'b0;
      end
      else
      begin
         finish <= run && halt_op && !finished;
         if (run && halt_op)
            finished <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (run && halt_op && !finished)
         is_fault <= (op == OP_FAULT);
   end

endmodule

/* hdl/run_control.sv */
//****************************************
// host start/finish handshake
//****************************************
`timescale 1ns/100ps

module run_control
(
   input  logic clk,
   input  logic reset,
   input  logic start_req,
   output logic start_ack,
   output logic done,
   output logic fault,
   output logic run,
   output logic clear,
   input  logic finish,
   input  logic is_fault
);

   typedef enum logic [1:0] {S_IDLE, S_RUN, S_ACK, S_RELEASE} state_t;

   state_t state;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state     <= S_IDLE;
         start_ack <= 1'b0;
         done      <= 1'b0;
         fault     <= 1'b0;
         run       <= 1'b0;
         clear     <= 1'b0;
      end
      else
      begin
         clear <= 1'b0;
         case (state)
            S_IDLE:
               if (start_req)
               begin
                  clear <= 1'b1;       // pc and registers back to zero
                  done  <= 1'b0;
                  fault <= 1'b0;
                  state <= S_RUN;
               end
            S_RUN:
            begin
               run <= 1'b1;
               if (finish)
               begin
                  start_ack <= 1'b1;
                  done      <= !is_fault;
                  fault     <= is_fault;
                  state     <= S_ACK;
               end
            end
            S_ACK:
               if (!start_req)
               begin
                  start_ack <= 1'b0;
                  run       <= 1'b0;
                  state     <= S_RELEASE;
               end
            default:
               state <= S_IDLE;        // one quiet cycle
         endcase
      end
   end

endmodule

/* hdl/bus_master.sv */
//****************************************
// four-phase memory bus master
//****************************************
`timescale 1ns/100ps

module bus_master import bus_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  op_start,
   input  logic                  op_write,
   input  logic [ADDR_WIDTH-1:0] op_addr,
   input  logic [DATA_WIDTH-1:0] op_wdata,
   output logic                  op_done,
   output logic [DATA_WIDTH-1:0] op_rdata,
   output logic                  mem_req,
   output logic                  mem_we,
   output logic [ADDR_WIDTH-1:0] mem_addr,
   output logic [DATA_WIDTH-1:0] mem_wdata,
   input  logic                  mem_ack,
   input  logic [DATA_WIDTH-1:0] mem_rdata
);

   typedef enum logic [1:0] {S_IDLE, S_WAIT_ACK, S_WAIT_REL, S_DONE} state_t;

   state_t state;

   assign mem_req = (state == S_WAIT_ACK);
   assign op_done = (state == S_DONE);

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= S_IDLE;
      else
      begin
         case (state)
            S_IDLE:
               if (op_start)
                  state <= S_WAIT_ACK;
            S_WAIT_ACK:
               if (mem_ack)
                  state <= S_WAIT_REL;
            S_WAIT_REL:
               if (!mem_ack)
                  state <= S_DONE;
            default:
               state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == S_IDLE && op_start)
      begin
         mem_we    <= op_write;
         mem_addr  <= op_addr;
         mem_wdata <= op_wdata;
      end
      if (state == S_WAIT_ACK && mem_ack)
         op_rdata <= mem_rdata;  // valid with ack
   end

endmodule

/* hdl/test_cpu_top.sv */
//****************************************
// test processor top level
// run control, sequencer and bus master
//****************************************
`timescale 1ns/100ps

module test_cpu_top import bus_pkg::*;
#(
   parameter int BLOCK_WORDS = 16
)
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  start_req,
   output logic                  start_ack,
   output logic                  done,
   output logic                  fault,
   output logic                  mem_req,
   output logic                  mem_we,
   output logic [ADDR_WIDTH-1:0] mem_addr,
   output logic [DATA_WIDTH-1:0] mem_wdata,
   input  logic                  mem_ack,
   input  logic [DATA_WIDTH-1:0] mem_rdata
);

   logic                  run, clear, finish, is_fault;
   logic                  op_start, op_write, op_done;
   logic [ADDR_WIDTH-1:0] op_addr;
   logic [DATA_WIDTH-1:0] op_wdata, op_rdata;

   run_control ctl (
      .clk      (clk),
      .reset    (reset),
      .start_req(start_req),
      .start_ack(start_ack),
      .done     (done),
      .fault    (fault),
      .run      (run),
      .clear    (clear),
      .finish   (finish),
      .is_fault (is_fault)
   );

   test_cpu #(
      .BLOCK_WORDS(BLOCK_WORDS)
   ) cpu (
      .clk     (clk),
      .reset   (reset),
      .run     (run),
      .clear   (clear),
      .finish  (finish),
      .is_fault(is_fault),
      .op_start(op_start),
      .op_write(op_write),
      .op_addr (op_addr),
      .op_wdata(op_wdata),
      .op_done (op_done),
      .op_rdata(op_rdata)
   );

   bus_master bus (
      .clk      (clk),
      .reset    (reset),
      .op_start (op_start),
      .op_write (op_write),
      .op_addr  (op_addr),
      .op_wdata (op_wdata),
      .op_done  (op_done),
      .op_rdata (op_rdata),
      .mem_req  (mem_req),
      .mem_we   (mem_we),
      .mem_addr (mem_addr),
      .mem_wdata(mem_wdata),
      .mem_ack  (mem_ack),
      .mem_rdata(mem_rdata)
   );

endmodule

/* verification/test_cpu_props.sv */
//****************************************
// four-phase handshake assertions
// bound to bus_master and run_control
//****************************************
`timescale 1ns/100ps

module test_cpu_props import bus_pkg::*;
(
   input logic                  clk,
   input logic                  reset,
   input logic                  req,
   input logic                  ack,
   input logic [ADDR_WIDTH-1:0] addr
);

   int assert_fails = 0;   // summed by the testbench

   req_fall_after_ack: assert property (@(posedge clk) disable iff (reset)
      $fell(req) |-> $past(ack))
   else
   begin
      assert_fails++;
      $error("req dropped before ack was high");
   end

   addr_stable_in_req: assert property (@(posedge clk) disable iff (reset)
      req && $past(req) |-> $stable(addr))
   else
   begin
      assert_fails++;
      $error("address changed while req was high");
   end

   ack_fall_after_req: assert property (@(posedge clk) disable iff (reset)
      $fell(ack) |-> !req)
   else
   begin
      assert_fails++;
      $error("ack dropped while req was still high");
   end

endmodule

bind bus_master test_cpu_props mem_props (
   .clk  (clk),
   .reset(reset),
   .req  (mem_req),
   .ack  (mem_ack),
   .addr (mem_addr)
);

bind run_control test_cpu_props host_props (
   .clk  (clk),
   .reset(reset),
   .req  (start_req),
   .ack  (start_ack),
   .addr ('0)                  // no address on the host side
);

/* verification/tb_test_cpu.sv */
//****************************************
// testbench for the test processor
// clock, host driver, memory model, reference, checks
//****************************************
`timescale 1ns/100ps

module tb_test_cpu import bus_pkg::*;
();

   localparam int BLOCK_WORDS = 16;
   localparam int RUN_TIMEOUT = 4000;      // cycles per program run
   localparam int ACK_TIMEOUT = 16;

   logic                  clk;
   logic                  reset;
   logic                  start_req;
   logic                  start_ack;
   logic                  done;
   logic                  fault;
   logic                  mem_req;
   logic                  mem_we;
   logic [ADDR_WIDTH-1:0] mem_addr;
   logic [DATA_WIDTH-1:0] mem_wdata;
   logic                  mem_ack;
   logic [DATA_WIDTH-1:0] mem_rdata;

   logic [DATA_WIDTH-1:0] mem [logic [ADDR_WIDTH-1:0]];
   logic [15:0]           lfsr;
   logic                  corrupt_on;
   int                    corrupt_idx;
   logic [ADDR_WIDTH-1:0] corrupt_addr;
   logic [DATA_WIDTH-1:0] corrupt_mask;
   int                    run_base;
   int                    exp_count;
   int                    cycle_cnt = 0;
   int                    bus_errors = 0;
   int                    host_errors = 0;
   int                    mem_errors = 0;
   int                    timeouts = 0;

   test_cpu_top #(
      .BLOCK_WORDS(BLOCK_WORDS)
   ) dut (
      .clk      (clk),
      .reset    (reset),
      .start_req(start_req),
      .start_ack(start_ack),
      .done     (done),
      .fault    (fault),
      .mem_req  (mem_req),
      .mem_we   (mem_we),
      .mem_addr (mem_addr),
      .mem_wdata(mem_wdata),
      .mem_ack  (mem_ack),
      .mem_rdata(mem_rdata)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // x^16 + x^14 + x^13 + x^11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic random_bits(input int n, output int value);
      value = 0;
      for (int i = 0; i < n; i++)
      begin
         lfsr  = lfsr_next(lfsr);
         value = (value << 1) | int'(lfsr[0]);
      end
   endtask

   // k-th bus cycle of a run: fill writes, then ascending reads
   function automatic void expected_cycle(input int k,
                                          output logic we,
                                          output logic [ADDR_WIDTH-1:0] addr,
                                          output logic [DATA_WIDTH-1:0] data);
      int idx;
      we   = (k < BLOCK_WORDS);
      idx  = we ? k : k - BLOCK_WORDS;
      addr = MEM_BASE + ADDR_WIDTH'(idx);
      data = {~addr[15:0], addr[15:0]};
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("Fail at %0d ns: %s = %h, expected %h", $time, name, got, exp);
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         report_mismatch(name, 32'(got), 32'(exp));
         host_errors++;
      end
   endtask

   // memory with a random ack delay per bus cycle
   initial
   begin
      int delay;
      int waited;
      mem_ack   = 1'b0;
      mem_rdata = '0;
      forever
      begin
         @(negedge clk);
         if (!reset && mem_req && !mem_ack)
         begin
            random_bits(3, delay);
            repeat (delay) @(negedge clk);
            if (mem_we)
               mem[mem_addr] = (corrupt_on && mem_addr == corrupt_addr) ?
                               mem_wdata ^ corrupt_mask : mem_wdata;
            else
               mem_rdata = mem.exists(mem_addr) ? mem[mem_addr] : '0;
            mem_ack = 1'b1;
            waited  = 0;
            while (mem_req && waited < ACK_TIMEOUT)
            begin
               @(negedge clk);
               waited++;
            end
            if (mem_req)
            begin
               $display("Error: mem_req still high %0d cycles after mem_ack", ACK_TIMEOUT);
               mem_errors++;
            end
            mem_ack = 1'b0;
         end
      end
   end

   // one compare per bus cycle, at the edge that sees the ack
   always @(posedge clk)
   begin
      int                    k;
      logic                  exp_we;
      logic [ADDR_WIDTH-1:0] exp_addr;
      logic [DATA_WIDTH-1:0] exp_data;
      if (!reset && mem_req && mem_ack)
      begin
         k = cycle_cnt - run_base;
         if (k >= exp_count)
         begin
            $display("Error: extra bus cycle to address %h after the expected sequence",
                     mem_addr);
            bus_errors++;
         end
         else
         begin
            expected_cycle(k, exp_we, exp_addr, exp_data);
            if (mem_we !== exp_we)
            begin
               report_mismatch("mem_we", 32'(mem_we), 32'(exp_we));
               bus_errors++;
            end
            if (mem_addr !== exp_addr)
            begin
               report_mismatch("mem_addr", 32'(mem_addr), 32'(exp_addr));
               bus_errors++;
            end
            if (exp_we && mem_wdata !== exp_data)
            begin
               report_mismatch("mem_wdata", mem_wdata, exp_data);
               bus_errors++;
            end
         end
         cycle_cnt = cycle_cnt + 1;
      end
   end

   // one start handshake, optionally with a damaged word
   task automatic run_program(input logic inject);
      int   value;
      int   waited;
      int   seen;
      logic exp_done;
      exp_done   = !inject;
      corrupt_on = inject;
      if (inject)
      begin
         random_bits(8, value);
         corrupt_idx = value % BLOCK_WORDS;
         random_bits(5, value);
         corrupt_mask = 32'd1 << value;
         corrupt_addr = MEM_BASE + ADDR_WIDTH'(corrupt_idx);
         exp_count    = BLOCK_WORDS + corrupt_idx + 1;   // reads stop at the bad word
      end
      else
      begin
         corrupt_idx  = -1;
         corrupt_mask = '0;
         corrupt_addr = '0;
         exp_count    = 2 * BLOCK_WORDS;
      end
      mem.delete();
      run_base = cycle_cnt;

      @(negedge clk);
      start_req = 1'b1;
      waited    = 0;
      while (!start_ack && waited < RUN_TIMEOUT)
      begin
         @(negedge clk);
         waited++;
      end
      if (!start_ack)
      begin
         $display("Error: no start_ack within %0d cycles of start_req", RUN_TIMEOUT);
         timeouts++;
         return;
      end
      check_bit("done", done, exp_done);
      check_bit("fault", fault, !exp_done);

      // result must hold until the host lets go
      for (int i = 0; i < 3; i++)
      begin
         @(negedge clk);
         check_bit("start_ack", start_ack, 1'b1);
         check_bit("done", done, exp_done);
         check_bit("fault", fault, !exp_done);
      end

      start_req = 1'b0;
      waited    = 0;
      while (start_ack && waited < ACK_TIMEOUT)
      begin
         @(negedge clk);
         waited++;
      end
      if (start_ack)
      begin
         $display("Error: start_ack stayed high after start_req was dropped");
         timeouts++;
         return;
      end

      seen = cycle_cnt - run_base;
      if (seen != exp_count)
      begin
         $display("Fail at %0d ns: bus cycle count = %0d, expected %0d",
                  $time, seen, exp_count);
         host_errors++;
      end
      repeat (2) @(negedge clk);
   endtask

   initial
   begin
      int assert_fails;
      int total;
      reset     = 1'b1;
      start_req = 1'b0;
      lfsr      = 16'd58982;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      check_bit("start_ack", start_ack, 1'b0);
      check_bit("mem_req", mem_req, 1'b0);

      run_program(1'b0);            // clean fill and verify
      if (timeouts == 0)
         run_program(1'b1);         // damaged word ends in fault
      if (timeouts == 0)
         run_program(1'b0);         // clean again after the fault

      assert_fails = dut.bus.mem_props.assert_fails + dut.ctl.host_props.assert_fails;
      total = bus_errors + host_errors + mem_errors + timeouts + assert_fails;
      $display("errors: bus %0d, host %0d, memory %0d, assertion %0d, timeout %0d",
               bus_errors, host_errors, mem_errors, assert_fails, timeouts);
      if (total == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

/* src.f */
hdl/cpu_isa_pkg.sv
hdl/bus_pkg.sv
hdl/microcode_rom.sv
hdl/test_cpu.sv
hdl/run_control.sv
hdl/bus_master.sv
hdl/test_cpu_top.sv
verification/test_cpu_props.sv
verification/tb_test_cpu.sv

/* Makefile */
# Verilator lint and simulation of the test processor

VERILATOR ?= verilator
TOP       ?= tb_test_cpu
SRC_F     ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Simulation finished: PASS

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(SRC_F)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(SRC_F)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
